// ==== design/layer_ctrl_macros.svh ====
// layer controller macros: descriptor limits, ring capacity, pipeline depth and writeback delay
`ifndef LAYER_CTRL_MACROS_SVH
`define LAYER_CTRL_MACROS_SVH

// ----------------------------------------------------------------------
// layer descriptor limits
// ----------------------------------------------------------------------
`define LC_K_MAX 3         // largest kernel size
`define LC_NI_MAX 128      // largest input channel count
`define LC_NO_MAX 128      // largest output channel count
`define LC_IMG_W_MAX 224   // largest image width
`define LC_IMG_H_MAX 224   // largest image height

// ----------------------------------------------------------------------
// sequencing
// ----------------------------------------------------------------------
// number of layer descriptors the ring can hold
`define LC_RING_DEPTH 8

`define LC_PIPE_DEPTH 2    // compute and weight pipeline stages

// cycles between tile buffer done and the next layer switch
`define LC_WB_DELAY 2

`endif

// ==== design/layer_ctrl_pkg.sv ====
// layer controller package: layer descriptor, sequencer states and stage mask helper
`default_nettype none
`include "layer_ctrl_macros.svh"

package layer_ctrl_pkg;

   // field widths, one bit extra so each count can hold its maximum
   localparam int unsigned K_W      = $clog2(`LC_K_MAX) + 1;
   localparam int unsigned NI_W     = $clog2(`LC_NI_MAX) + 1;
   localparam int unsigned NO_W     = $clog2(`LC_NO_MAX) + 1;
   localparam int unsigned IMG_W_W  = $clog2(`LC_IMG_W_MAX) + 1;
   localparam int unsigned IMG_H_W  = $clog2(`LC_IMG_H_MAX) + 1;
   localparam int unsigned STRIDE_W = $clog2(`LC_K_MAX);
   localparam int unsigned CNT_W    = $clog2(`LC_RING_DEPTH) + 1;

   typedef struct packed {
      logic [K_W-1:0]      k;
      logic [NI_W-1:0]     ni;
      logic [NO_W-1:0]     no;
      logic [IMG_W_W-1:0]  imagewidth;
      logic [IMG_H_W-1:0]  imageheight;
      logic [STRIDE_W-1:0] stride_width;
      logic [STRIDE_W-1:0] stride_height;
      logic                padding_type;
   } layer_t;

   typedef logic [CNT_W-1:0]          layer_cnt_t;   // layer index and ring count
   typedef logic                      bank_t;        // activation bankset select
   typedef logic [`LC_PIPE_DEPTH-1:0] stage_mask_t;  // one bit per pipeline stage

   typedef enum logic [2:0] {
      IDLE,
      LATCH,
      COMPUTE,
      WRITEBACK,
      FINISH
   } seq_state_e;

   // stages in use: ceil(no / channels per stage)
   function automatic stage_mask_t stage_mask(input layer_t layer);
      int unsigned per_stage;
      int unsigned n_stages;
      int unsigned s;
      stage_mask_t mask;
      per_stage = `LC_NO_MAX / `LC_PIPE_DEPTH;
      n_stages  = (layer.no + per_stage - 1) / per_stage;
      for (s = 0; s < `LC_PIPE_DEPTH; s++) begin
         mask[s] = (s < n_stages);
      end
      return mask;
   endfunction

endpackage

`default_nettype wire

// ==== design/layer_ring_if.sv ====
// layer ring interface: store, recirculating pop and ring status between ring and users
`timescale 1ns/1ps
`default_nettype none

interface layer_ring_if;

   import layer_ctrl_pkg::*;

   logic       push;   // store wdata at the tail
   logic       pop;    // move head to tail
   layer_t     wdata;
   layer_t     head;
   logic       empty;
   layer_cnt_t count;  // stored layers

   modport ring (
      input  push,
      input  pop,
      input  wdata,
      output head,
      output empty,
      output count
   );

   modport user (
      output push,
      output pop,
      output wdata,
      input  head,
      input  empty,
      input  count
   );

endinterface

`default_nettype wire

// ==== design/layer_ring.sv ====
// layer ring: recirculating FIFO that keeps the stored layer program across iterations
`timescale 1ns/1ps
`default_nettype none
`include "layer_ctrl_macros.svh"

module layer_ring #(
   parameter int unsigned DEPTH = `LC_RING_DEPTH
) (
   input  wire logic       clk_i,
   input  wire logic       rst_ni,
   layer_ring_if.ring      ring
);

   import layer_ctrl_pkg::*;

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   typedef logic [PTR_W-1:0] ptr_t;

   layer_t     mem_q [DEPTH];
   ptr_t       rd_ptr_q;
   ptr_t       wr_ptr_q;
   layer_cnt_t cnt_q;
   logic       full;
   logic       do_recirc;
   logic       do_push;

   function automatic ptr_t next_ptr(input ptr_t p);
      return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
   endfunction

   assign full      = (cnt_q == layer_cnt_t'(DEPTH));
   assign do_recirc = ring.pop && (cnt_q != '0);
   assign do_push   = ring.push && !full && !do_recirc;  // pushes while full are dropped

   assign ring.head  = mem_q[rd_ptr_q];
   assign ring.empty = (cnt_q == '0);
   assign ring.count = cnt_q;

   // ----------------------------------------------------------------------
   // pointers and occupancy
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         cnt_q    <= '0;
      end else if (do_recirc) begin
         // head leaves and re-enters at the tail, occupancy unchanged
         rd_ptr_q <= next_ptr(rd_ptr_q);
         wr_ptr_q <= next_ptr(wr_ptr_q);
      end else if (do_push) begin
         wr_ptr_q <= next_ptr(wr_ptr_q);
         cnt_q    <= cnt_q + layer_cnt_t'(1);
      end
   end

   // ----------------------------------------------------------------------
   // storage
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (do_recirc) begin
         mem_q[wr_ptr_q] <= mem_q[rd_ptr_q];
      end else if (do_push) begin
         mem_q[wr_ptr_q] <= ring.wdata;
      end
   end

endmodule

`default_nettype wire

// ==== design/layer_sequencer.sv ====
// layer sequencer: compute-side FSM stepping through the stored layers of one iteration
`timescale 1ns/1ps
`default_nettype none
`include "layer_ctrl_macros.svh"

module layer_sequencer (
   input  wire logic                   clk_i,
   input  wire logic                   rst_ni,
   input  wire logic                   start_i,
   input  wire logic                   tilebuffer_done_i,
   layer_ring_if.user                  ring,
   output logic                        idle_o,
   output logic                        iter_start_o,
   output logic                        layer_pop_o,
   output logic                        compute_latch_o,
   output logic                        compute_soft_reset_o,
   output layer_ctrl_pkg::stage_mask_t compute_toggle_o,
   output layer_ctrl_pkg::layer_t      current_o,
   output layer_ctrl_pkg::bank_t       readbank_o,
   output layer_ctrl_pkg::bank_t       writebank_o,
   output logic                        done_o
);

   import layer_ctrl_pkg::*;

   localparam int unsigned WB_W = $clog2(`LC_WB_DELAY + 1);
   localparam logic [WB_W-1:0] WB_LAST = WB_W'(`LC_WB_DELAY - 1);

   seq_state_e      state_q, state_d;
   layer_cnt_t      idx_q, idx_d;        // index of the next layer to latch
   logic [WB_W-1:0] wb_cnt_q, wb_cnt_d;
   bank_t           rdbank_q, rdbank_d;
   bank_t           wrbank_q, wrbank_d;
   layer_t          cur_q;

   // ----------------------------------------------------------------------
   // next state and pulses
   // ----------------------------------------------------------------------
   always_comb begin : seq_fsm
      state_d  = state_q;
      idx_d    = idx_q;
      wb_cnt_d = wb_cnt_q;
      rdbank_d = rdbank_q;
      wrbank_d = wrbank_q;

      idle_o               = 1'b0;
      iter_start_o         = 1'b0;
      layer_pop_o          = 1'b0;
      compute_latch_o      = 1'b0;
      compute_soft_reset_o = 1'b0;
      compute_toggle_o     = '0;
      done_o               = 1'b0;

      unique case (state_q)
         IDLE: begin
            idle_o = 1'b1;
            if (start_i && !ring.empty) begin  // nothing to run on an empty ring
               iter_start_o = 1'b1;
               idx_d        = '0;
               state_d      = LATCH;
            end
         end
         LATCH: begin
            compute_latch_o      = 1'b1;
            layer_pop_o          = 1'b1;
            compute_toggle_o     = stage_mask(ring.head);
            compute_soft_reset_o = (idx_q == '0);
            // banks follow index parity
            rdbank_d = idx_q[0];
            wrbank_d = ~idx_q[0];
            idx_d    = idx_q + layer_cnt_t'(1);
            state_d  = COMPUTE;
         end
         COMPUTE: begin
            if (tilebuffer_done_i) begin
               wb_cnt_d = '0;
               state_d  = WRITEBACK;
            end
         end
         WRITEBACK: begin
            if (wb_cnt_q == WB_LAST) begin
               state_d = (idx_q == ring.count) ? FINISH : LATCH;
            end else begin
               wb_cnt_d = wb_cnt_q + WB_W'(1);
            end
         end
         FINISH: begin
            done_o  = 1'b1;
            state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   assign ring.pop    = layer_pop_o;  // recirculate the head on every latch
   assign current_o   = cur_q;
   assign readbank_o  = rdbank_q;
   assign writebank_o = wrbank_q;

   // ----------------------------------------------------------------------
   // state registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q  <= IDLE;
         idx_q    <= '0;
         wb_cnt_q <= '0;
         rdbank_q <= 1'b1;
         wrbank_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         idx_q    <= idx_d;
         wb_cnt_q <= wb_cnt_d;
         rdbank_q <= rdbank_d;
         wrbank_q <= wrbank_d;
      end
   end

   // current layer, loaded from the ring head at the end of LATCH
   always_ff @(posedge clk_i) begin
      if (state_q == LATCH) begin
         cur_q <= ring.head;
      end
   end

endmodule

`default_nettype wire

// ==== design/weight_prefetch.sv ====
// weight prefetcher: hands the upcoming layer's parameters to the weight loaders
`timescale 1ns/1ps
`default_nettype none

module weight_prefetch (
   input  wire logic                         clk_i,
   input  wire logic                         rst_ni,
   input  wire logic                         iter_start_i,
   input  wire logic                         layer_pop_i,
   input  wire logic                         weightload_done_i,
   input  wire layer_ctrl_pkg::layer_t       head_i,
   input  wire layer_ctrl_pkg::layer_cnt_t   count_i,
   output layer_ctrl_pkg::stage_mask_t       weights_latch_o,
   output layer_ctrl_pkg::stage_mask_t       weights_soft_reset_o,
   output logic [layer_ctrl_pkg::K_W-1:0]    weights_k_o,
   output logic [layer_ctrl_pkg::NI_W-1:0]   weights_ni_o,
   output logic [layer_ctrl_pkg::NO_W-1:0]   weights_no_o
);

   import layer_ctrl_pkg::*;

   logic        armed_q;    // one latch allowed per ring pop
   logic        running_q;  // iteration still needs weights
   layer_cnt_t  widx_q;     // weight-side layer index
   logic        latch;
   stage_mask_t head_mask;

   assign head_mask = stage_mask(head_i);
   assign latch     = weightload_done_i && armed_q && running_q && (widx_q < count_i);

   assign weights_latch_o      = latch ? head_mask : '0;
   assign weights_soft_reset_o = (latch && widx_q == '0) ? head_mask : '0;

   // parameters always follow the ring head
   assign weights_k_o  = head_i.k;
   assign weights_ni_o = head_i.ni;
   assign weights_no_o = head_i.no;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         armed_q   <= 1'b0;
         running_q <= 1'b0;
         widx_q    <= '0;
      end else if (iter_start_i) begin
         armed_q   <= 1'b1;
         running_q <= 1'b1;
         widx_q    <= '0;
      end else begin
         if (latch) begin
            armed_q <= 1'b0;
            widx_q  <= widx_q + layer_cnt_t'(1);
            if (widx_q + layer_cnt_t'(1) == count_i) begin
               running_q <= 1'b0;  // last layer of the iteration handed out
            end
         end
         // a pop moves the head on, so the next layer may be loaded
         if (layer_pop_i) begin
            armed_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/layer_ctrl_top.sv ====
// layer controller top: layer ring, compute sequencer and weight prefetcher
`timescale 1ns/1ps
`default_nettype none
`include "layer_ctrl_macros.svh"

module layer_ctrl_top (
   input  wire logic                            clk_i,
   input  wire logic                            rst_ni,
   // layer store port
   input  wire logic                            store_i,
   input  wire logic [$clog2(`LC_K_MAX):0]      layer_k_i,
   input  wire logic [$clog2(`LC_NI_MAX):0]     layer_ni_i,
   input  wire logic [$clog2(`LC_NO_MAX):0]     layer_no_i,
   input  wire logic [$clog2(`LC_IMG_W_MAX):0]  layer_imagewidth_i,
   input  wire logic [$clog2(`LC_IMG_H_MAX):0]  layer_imageheight_i,
   input  wire logic [$clog2(`LC_K_MAX)-1:0]    layer_stride_width_i,
   input  wire logic [$clog2(`LC_K_MAX)-1:0]    layer_stride_height_i,
   input  wire logic                            layer_padding_type_i,
   // iteration control
   input  wire logic                            start_i,
   input  wire logic                            tilebuffer_done_i,
   input  wire logic                            weightload_done_i,
   // compute side
   output logic                                 compute_latch_o,
   output logic                                 compute_soft_reset_o,
   output logic [`LC_PIPE_DEPTH-1:0]            compute_toggle_o,
   output logic [$clog2(`LC_K_MAX):0]           compute_k_o,
   output logic [$clog2(`LC_NI_MAX):0]          compute_ni_o,
   output logic [$clog2(`LC_NO_MAX):0]          compute_no_o,
   output logic [$clog2(`LC_IMG_W_MAX):0]       compute_imagewidth_o,
   output logic [$clog2(`LC_IMG_H_MAX):0]       compute_imageheight_o,
   output logic [$clog2(`LC_K_MAX)-1:0]         compute_stride_width_o,
   output logic [$clog2(`LC_K_MAX)-1:0]         compute_stride_height_o,
   output logic                                 compute_padding_type_o,
   output logic                                 readbank_o,
   output logic                                 writebank_o,
   // weight side
   output logic [`LC_PIPE_DEPTH-1:0]            weights_latch_o,
   output logic [`LC_PIPE_DEPTH-1:0]            weights_soft_reset_o,
   output logic [$clog2(`LC_K_MAX):0]           weights_k_o,
   output logic [$clog2(`LC_NI_MAX):0]          weights_ni_o,
   output logic [$clog2(`LC_NO_MAX):0]          weights_no_o,
   output logic                                 done_o
);

   import layer_ctrl_pkg::*;

   layer_t store_layer;
   layer_t cur_layer;
   logic   seq_idle;
   logic   iter_start;
   logic   layer_pop;

   layer_ring_if ring_bus ();

   always_comb begin : pack_layer
      store_layer.k             = layer_k_i;
      store_layer.ni            = layer_ni_i;
      store_layer.no            = layer_no_i;
      store_layer.imagewidth    = layer_imagewidth_i;
      store_layer.imageheight   = layer_imageheight_i;
      store_layer.stride_width  = layer_stride_width_i;
      store_layer.stride_height = layer_stride_height_i;
      store_layer.padding_type  = layer_padding_type_i;
   end

   assign ring_bus.push  = store_i && seq_idle;  // program is frozen while running
   assign ring_bus.wdata = store_layer;

   assign compute_k_o             = cur_layer.k;
   assign compute_ni_o            = cur_layer.ni;
   assign compute_no_o            = cur_layer.no;
   assign compute_imagewidth_o    = cur_layer.imagewidth;
   assign compute_imageheight_o   = cur_layer.imageheight;
   assign compute_stride_width_o  = cur_layer.stride_width;
   assign compute_stride_height_o = cur_layer.stride_height;
   assign compute_padding_type_o  = cur_layer.padding_type;

   layer_ring #(.DEPTH(`LC_RING_DEPTH)) u_ring (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .ring   (ring_bus)
   );

   layer_sequencer u_seq (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .start_i              (start_i),
      .tilebuffer_done_i    (tilebuffer_done_i),
      .ring                 (ring_bus),
      .idle_o               (seq_idle),
      .iter_start_o         (iter_start),
      .layer_pop_o          (layer_pop),
      .compute_latch_o      (compute_latch_o),
      .compute_soft_reset_o (compute_soft_reset_o),
      .compute_toggle_o     (compute_toggle_o),
      .current_o            (cur_layer),
      .readbank_o           (readbank_o),
      .writebank_o          (writebank_o),
      .done_o               (done_o)
   );

   weight_prefetch u_wpf (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .iter_start_i         (iter_start),
      .layer_pop_i          (layer_pop),
      .weightload_done_i    (weightload_done_i),
      .head_i               (ring_bus.head),
      .count_i              (ring_bus.count),
      .weights_latch_o      (weights_latch_o),
      .weights_soft_reset_o (weights_soft_reset_o),
      .weights_k_o          (weights_k_o),
      .weights_ni_o         (weights_ni_o),
      .weights_no_o         (weights_no_o)
   );

endmodule

`default_nettype wire

// ==== verif/layer_ctrl_chk.sv ====
// layer controller checker: concurrent assertions on top-level pulses and bank selects
`timescale 1ns/1ps
`default_nettype none

module layer_ctrl_chk (
   input wire logic                        clk_i,
   input wire logic                        rst_ni,
   input wire logic                        compute_latch_i,
   input wire logic                        done_i,
   input wire layer_ctrl_pkg::stage_mask_t weights_latch_i,
   input wire logic                        weightload_done_i,
   input wire logic                        readbank_i,
   input wire logic                        writebank_i
);

   int unsigned fail_cnt = 0;  // failed assertions so far

   latch_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      compute_latch_i |=> !compute_latch_i)
      else begin
         fail_cnt++;
         $error("compute latch held for more than one cycle");
      end

   // FINISH and LATCH are separate states
   done_not_with_latch: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(done_i && compute_latch_i))
      else begin
         fail_cnt++;
         $error("done and compute latch high together");
      end

   weights_need_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (weights_latch_i != '0) |-> weightload_done_i)
      else begin
         fail_cnt++;
         $error("weight latch without weight load done");
      end

   banks_differ: assert property (@(posedge clk_i) disable iff (!rst_ni)
      readbank_i != writebank_i)
      else begin
         fail_cnt++;
         $error("read and write bank are the same");
      end

endmodule

bind layer_ctrl_top layer_ctrl_chk u_chk (
   .clk_i             (clk_i),
   .rst_ni            (rst_ni),
   .compute_latch_i   (compute_latch_o),
   .done_i            (done_o),
   .weights_latch_i   (weights_latch_o),
   .weightload_done_i (weightload_done_i),
   .readbank_i        (readbank_o),
   .writebank_i       (writebank_o)
);

`default_nettype wire

// ==== verif/layer_ctrl_tb.sv ====
// layer controller testbench with directed tests of storage, sequencing, recirculation and prefetch
`timescale 1ns/1ps
`default_nettype none
`include "layer_ctrl_macros.svh"

module layer_ctrl_tb;

   import layer_ctrl_pkg::*;

   localparam time         CLK_PERIOD = 8ns;
   localparam int unsigned MAX_CYCLES = 2000;  // all tests together take a few hundred cycles

   logic            clk_i = 1'b0;
   logic            rst_ni;
   logic            store_i;
   layer_t          store_data;
   logic            start_i;
   logic            tilebuffer_done_i;
   logic            weightload_done_i;
   logic            compute_latch_o;
   logic            compute_soft_reset_o;
   stage_mask_t     compute_toggle_o;
   layer_t          compute_layer;       // compute_* parameter outputs
   bank_t           readbank_o;
   bank_t           writebank_o;
   stage_mask_t     weights_latch_o;
   stage_mask_t     weights_soft_reset_o;
   logic [K_W-1:0]  weights_k_o;
   logic [NI_W-1:0] weights_ni_o;
   logic [NO_W-1:0] weights_no_o;
   logic            done_o;

   int unsigned cycle_cnt;
   layer_t      program_q[$];  // layers the ring should hold, in store order
   stage_mask_t wmask_q[$];    // weight latches seen
   stage_mask_t wsoft_q[$];
   layer_t      whead_q[$];    // k, ni, no handed to the weight loaders

   layer_ctrl_top uut (
      .clk_i                   (clk_i),
      .rst_ni                  (rst_ni),
      .store_i                 (store_i),
      .layer_k_i               (store_data.k),
      .layer_ni_i              (store_data.ni),
      .layer_no_i              (store_data.no),
      .layer_imagewidth_i      (store_data.imagewidth),
      .layer_imageheight_i     (store_data.imageheight),
      .layer_stride_width_i    (store_data.stride_width),
      .layer_stride_height_i   (store_data.stride_height),
      .layer_padding_type_i    (store_data.padding_type),
      .start_i                 (start_i),
      .tilebuffer_done_i       (tilebuffer_done_i),
      .weightload_done_i       (weightload_done_i),
      .compute_latch_o         (compute_latch_o),
      .compute_soft_reset_o    (compute_soft_reset_o),
      .compute_toggle_o        (compute_toggle_o),
      .compute_k_o             (compute_layer.k),
      .compute_ni_o            (compute_layer.ni),
      .compute_no_o            (compute_layer.no),
      .compute_imagewidth_o    (compute_layer.imagewidth),
      .compute_imageheight_o   (compute_layer.imageheight),
      .compute_stride_width_o  (compute_layer.stride_width),
      .compute_stride_height_o (compute_layer.stride_height),
      .compute_padding_type_o  (compute_layer.padding_type),
      .readbank_o              (readbank_o),
      .writebank_o             (writebank_o),
      .weights_latch_o         (weights_latch_o),
      .weights_soft_reset_o    (weights_soft_reset_o),
      .weights_k_o             (weights_k_o),
      .weights_ni_o            (weights_ni_o),
      .weights_no_o            (weights_no_o),
      .done_o                  (done_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // ----------------------------------------------------------------------
   // error reporting and compare tasks
   // ----------------------------------------------------------------------
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_layer(input string name, input layer_t exp, input layer_t act);
      if (act !== exp) abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_mask(input string name, input stage_mask_t exp, input stage_mask_t act);
      if (act !== exp) abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
   endtask

   task automatic check_bank(input string name, input bank_t exp, input bank_t act);
      if (act !== exp) abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
   endtask

   task automatic check_count(input string name, input layer_cnt_t exp, input layer_cnt_t act);
      if (act !== exp) abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
   endtask

   always @(posedge clk_i) begin : watchdog
      cycle_cnt++;
      if (uut.u_chk.fail_cnt != 0) begin
         abort_run("an assertion in the bound checker failed");
      end else if (cycle_cnt >= MAX_CYCLES) begin
         abort_run("timeout: the DUT did not finish the tests within the cycle limit");
      end
   end

   // record every weight latch, sampled mid-cycle
   always @(negedge clk_i) begin : weight_monitor
      layer_t seen;
      if (rst_ni === 1'b1 && weights_latch_o != '0) begin
         seen    = '0;
         seen.k  = weights_k_o;
         seen.ni = weights_ni_o;
         seen.no = weights_no_o;
         wmask_q.push_back(weights_latch_o);
         wsoft_q.push_back(weights_soft_reset_o);
         whead_q.push_back(seen);
      end
   end

   // ----------------------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------------------
   // ceil(no / channels per stage) stages, lowest stages first
   function automatic stage_mask_t expected_mask(input layer_t l);
      int unsigned per_stage;
      int unsigned used;
      per_stage = `LC_NO_MAX / `LC_PIPE_DEPTH;
      used      = (l.no + per_stage - 1) / per_stage;
      return stage_mask_t'((1 << used) - 1);
   endfunction

   function automatic layer_t random_layer(input int unsigned no_lo, input int unsigned no_hi);
      layer_t l;
      l.k             = K_W'($urandom_range(`LC_K_MAX, 1));
      l.ni            = NI_W'($urandom_range(`LC_NI_MAX, 1));
      l.no            = NO_W'($urandom_range(no_hi, no_lo));
      l.imagewidth    = IMG_W_W'($urandom_range(`LC_IMG_W_MAX, 1));
      l.imageheight   = IMG_H_W'($urandom_range(`LC_IMG_H_MAX, 1));
      l.stride_width  = STRIDE_W'($urandom_range(2, 1));
      l.stride_height = STRIDE_W'($urandom_range(2, 1));
      l.padding_type  = 1'($urandom_range(1, 0));
      return l;
   endfunction

   task automatic apply_reset();
      @(posedge clk_i);
      #1;
      rst_ni            = 1'b0;
      store_i           = 1'b0;
      store_data        = '0;
      start_i           = 1'b0;
      tilebuffer_done_i = 1'b0;
      weightload_done_i = 1'b0;
      program_q.delete();
      repeat (5) @(posedge clk_i);
      #1 rst_ni = 1'b1;
   endtask

   task automatic store_one(input layer_t l);
      @(posedge clk_i);
      #1;
      store_i    = 1'b1;
      store_data = l;
      @(posedge clk_i);
      #1 store_i = 1'b0;
      program_q.push_back(l);
   endtask

   task automatic pulse_start();
      @(posedge clk_i);
      #1 start_i = 1'b1;
      @(posedge clk_i);
      #1 start_i = 1'b0;
   endtask

   // one iteration over program_q; stall = busy cycles per layer, poke = store while running
   task automatic run_iteration(input string name, input int unsigned stall, input bit poke);
      int unsigned i;
      int unsigned w;
      layer_t      exp;
      pulse_start();
      for (i = 0; i < program_q.size(); i++) begin
         exp = program_q[i];
         @(negedge clk_i);  // LATCH
         check_bit({name, " latch"}, 1'b1, compute_latch_o);
         check_bit({name, " soft reset"}, (i == 0), compute_soft_reset_o);
         check_mask({name, " toggle"}, expected_mask(exp), compute_toggle_o);
         check_bit({name, " done during latch"}, 1'b0, done_o);
         @(negedge clk_i);  // COMPUTE with the layer in place
         check_layer({name, " layer"}, exp, compute_layer);
         check_bank({name, " readbank"}, bank_t'(i % 2), readbank_o);
         check_bank({name, " writebank"}, bank_t'((i + 1) % 2), writebank_o);
         for (w = 0; w < stall; w++) begin
            @(posedge clk_i);
            #1;
            if (poke) begin
               store_i    = 1'b1;
               store_data = random_layer(1, `LC_NO_MAX);
            end
            @(negedge clk_i);
            check_bit({name, " latch while busy"}, 1'b0, compute_latch_o);
            check_bit({name, " done while busy"}, 1'b0, done_o);
         end
         @(posedge clk_i);
         #1;
         store_i           = 1'b0;
         tilebuffer_done_i = 1'b1;
         @(posedge clk_i);
         #1 tilebuffer_done_i = 1'b0;
         repeat (`LC_WB_DELAY) begin
            @(negedge clk_i);
            check_bit({name, " latch in writeback"}, 1'b0, compute_latch_o);
            check_bit({name, " done in writeback"}, 1'b0, done_o);
         end
      end
      @(negedge clk_i);  // FINISH
      check_bit({name, " done"}, 1'b1, done_o);
      @(negedge clk_i);
      check_bit({name, " single done"}, 1'b0, done_o);
      check_bit({name, " latch after done"}, 1'b0, compute_latch_o);
   endtask

   // ----------------------------------------------------------------------
   // tests
   // ----------------------------------------------------------------------
   task automatic test_reset_values();
      apply_reset();
      @(negedge clk_i);
      check_bit("reset latch", 1'b0, compute_latch_o);
      check_bit("reset soft reset", 1'b0, compute_soft_reset_o);
      check_bit("reset done", 1'b0, done_o);
      check_mask("reset weights latch", '0, weights_latch_o);
      check_mask("reset weights soft reset", '0, weights_soft_reset_o);
      check_bank("reset readbank", 1'b1, readbank_o);
      check_bank("reset writebank", 1'b0, writebank_o);
      pulse_start();  // empty ring, must be ignored
      repeat (10) begin
         @(negedge clk_i);
         check_bit("empty start latch", 1'b0, compute_latch_o);
         check_bit("empty start done", 1'b0, done_o);
      end
   endtask

   task automatic test_weight_prefetch();
      int unsigned i;
      layer_t      exp;
      apply_reset();
      store_one(random_layer(1, `LC_NO_MAX / 2));
      store_one(random_layer(`LC_NO_MAX / 2 + 1, `LC_NO_MAX));
      store_one(random_layer(1, `LC_NO_MAX / 2));
      wmask_q.delete();
      wsoft_q.delete();
      whead_q.delete();
      weightload_done_i = 1'b1;
      run_iteration("weight prefetch", 2, 1'b0);
      @(posedge clk_i);
      #1 weightload_done_i = 1'b0;
      check_count("weight latch count", layer_cnt_t'(program_q.size()),
                  layer_cnt_t'(wmask_q.size()));
      for (i = 0; i < program_q.size(); i++) begin
         exp               = '0;
         exp.k             = program_q[i].k;
         exp.ni            = program_q[i].ni;
         exp.no            = program_q[i].no;
         check_mask("weight latch mask", expected_mask(program_q[i]), wmask_q[i]);
         check_mask("weight soft reset", (i == 0) ? expected_mask(program_q[i]) : '0,
                    wsoft_q[i]);
         check_layer("weight parameters", exp, whead_q[i]);
      end
   endtask

   initial begin : main
      int unsigned n;
      void'($urandom(32'h4a3f_4281));
      cycle_cnt         = 0;
      rst_ni            = 1'b0;  // start in reset
      store_i           = 1'b0;
      store_data        = '0;
      start_i           = 1'b0;
      tilebuffer_done_i = 1'b0;
      weightload_done_i = 1'b0;
      test_reset_values();
      apply_reset();
      store_one(random_layer(1, `LC_NO_MAX));
      run_iteration("one layer", 0, 1'b0);
      apply_reset();
      for (n = 0; n < 3; n++) store_one(random_layer(1, `LC_NO_MAX));
      run_iteration("three layers", 1, 1'b0);
      run_iteration("recirculation", 3, 1'b1);  // stores during the run are dropped
      run_iteration("recirculation rerun", 0, 1'b0);
      test_weight_prefetch();
      apply_reset();
      store_one(random_layer(1, `LC_NO_MAX));
      store_one(random_layer(1, `LC_NO_MAX));
      run_iteration("stall", 50, 1'b0);
      if (uut.u_chk.fail_cnt == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("checker reported %0d assertion failures", uut.u_chk.fail_cnt);
         $display("Test failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/layer_ctrl_pkg.sv
design/layer_ring_if.sv
design/layer_ring.sv
design/layer_sequencer.sv
design/weight_prefetch.sv
design/layer_ctrl_top.sv
verif/layer_ctrl_chk.sv
verif/layer_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: layer_ctrl

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/layer_ctrl_pkg.sv
      - design/layer_ring_if.sv
      - design/layer_ring.sv
      - design/layer_sequencer.sv
      - design/weight_prefetch.sv
      - design/layer_ctrl_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/layer_ctrl_chk.sv
      - verif/layer_ctrl_tb.sv
